// File: Makefile
TOP = tb_cpu_pin

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// File: files.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_bus_if.sv
hw/cpu_core.sv
hw/pin_serializer.sv
hw/cpu_pin_top.sv
tests/tb_cpu_pin.sv

// File: hw/cpu_bus_if.sv
// Word-wide memory transaction bus between the core and the pin serializer
`timescale 1ns/1ps

interface cpu_bus_if
  import cpu_pkg::*;
(
  input logic clk
);

  logic  req;    // Level, held until done
  logic  we;
  addr_t addr;
  word_t wdata;
  word_t rdata;  // Valid in the done cycle of a read
  logic  done;   // One-cycle pulse

  modport core (
    input  clk,
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport ser (
    input  clk,
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );

endinterface

// File: hw/cpu_core.sv
// Accumulator processor: fetch, execute and halt sequencing on the word bus
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  cpu_bus_if.core    bus
);

  core_state_t state;
  core_state_t state_nx;
  addr_t       pc;
  addr_t       pc_nx;
  word_t       acc;
  word_t       acc_nx;
  word_t       ir;        // Instruction being executed
  word_t       insn;      // Instruction under decode this cycle
  opcode_t     op;
  addr_t       opnd;

  // Operand field zero-extended to a word address
  function automatic addr_t operand_of(input word_t w);
    return addr_t'(w[`CPU_WORD_W-`OP_W-1:0]);
  endfunction

  // Fresh fetch data is decoded straight off the bus in its done cycle
  assign insn = (state == FETCH) ? bus.rdata : ir;
  assign op   = opcode_t'(insn[`CPU_WORD_W-1 -: `OP_W]);
  assign opnd = operand_of(insn);

  always_comb begin
    state_nx = state;
    pc_nx    = pc;
    acc_nx   = acc;
    case (state)
      FETCH: begin
        if (bus.done) begin
          pc_nx = pc + addr_t'(1);
          case (op)
            LOAD, ADD, SUB, STORE: state_nx = EXEC;  // Needs a data access
            JUMP: pc_nx = opnd;
            JZ: begin
              if (acc == '0) begin
                pc_nx = opnd;
              end
            end
            HALT: state_nx = HALTED;
            default: ;                                // NOP and unused codes
          endcase
        end
      end
      EXEC: begin
        if (bus.done) begin
          case (op)
            LOAD:    acc_nx = bus.rdata;
            ADD:     acc_nx = acc + bus.rdata;        // Wraps
            SUB:     acc_nx = acc - bus.rdata;
            default: ;                                // STORE leaves acc
          endcase
          state_nx = FETCH;
        end
      end
      default: ;                                      // HALTED stays put
    endcase
  end

  // Request follows the next state so a new access is ready in the done cycle
  always_comb begin
    bus.wdata = acc;
    case (state_nx)
      FETCH: begin
        bus.req  = 1'b1;
        bus.we   = 1'b0;
        bus.addr = pc_nx;
      end
      EXEC: begin
        bus.req  = 1'b1;
        bus.we   = (op == STORE);
        bus.addr = opnd;
      end
      default: begin
        bus.req  = 1'b0;
        bus.we   = 1'b0;
        bus.addr = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= FETCH;
      pc    <= '0;
      acc   <= '0;
    end else begin
      state <= state_nx;
      pc    <= pc_nx;
      acc   <= acc_nx;
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH && bus.done) begin
      ir <= bus.rdata;
    end
  end

  // A pending request holds still until the serializer completes it
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus.req && !bus.done) |=>
      (bus.done || ($stable(bus.addr) && $stable(bus.we) && $stable(bus.wdata))))
    else $error("core changed a pending bus request");

endmodule

// File: hw/cpu_params.svh
// Width, opcode field and frame-count macros for the core, bus and pin serializer
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_WORD_W        32  // Data word and word address width
`define PIN_W             8   // One pin group
`define BYTES_PER_WORD    4   // Pin bytes per word
`define OP_W              4   // Opcode field at the top of an instruction

// One access: latch frame, four address/write frames, four read frames
`define FRAMES_PER_ACCESS 9

`define ADDR_FRAME0       1   // First frame with address byte on the pins
`define READ_FRAME0       5   // First frame sampling read data

`endif

// File: hw/cpu_pin_top.sv
// Chip top: accumulator core and pin serializer on the 8-bit pin groups
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_pin_top (
  input  logic [`PIN_W-1:0] ui_in,
  output logic [`PIN_W-1:0] uo_out,
  input  logic [`PIN_W-1:0] uio_in,
  output logic [`PIN_W-1:0] uio_out,
  output logic [`PIN_W-1:0] uio_oe,
  input  logic              ena,
  input  logic              clk,
  input  logic              rst_n
);

  cpu_bus_if bus (
    .clk (clk)
  );

  cpu_core u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.core)
  );

  pin_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus.ser),
    .pin_out    (uo_out),
    .pin_io_out (uio_out),
    .pin_io_oe  (uio_oe),
    .pin_io_in  (uio_in)
  );

  // Dedicated inputs and enable have no function here
  logic unused_pins;
  assign unused_pins = &{ena, ui_in, 1'b0};

endmodule

// File: hw/cpu_pkg.sv
// Shared types: word, address, pin byte, frame index, opcode and core state enums
`include "cpu_params.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;   // Instruction or data word
  typedef logic [`CPU_WORD_W-1:0] addr_t;   // Word address
  typedef logic [`PIN_W-1:0]      pin_byte_t;

  typedef logic [$clog2(`FRAMES_PER_ACCESS)-1:0] frame_t;  // 0 to 8

  // Top nibble of an instruction; unlisted codes behave as NOP
  typedef enum logic [`OP_W-1:0] {
    NOP   = 4'd0,
    LOAD  = 4'd1,
    ADD   = 4'd2,
    SUB   = 4'd3,
    STORE = 4'd4,
    JUMP  = 4'd5,
    JZ    = 4'd6,
    HALT  = 4'd15
  } opcode_t;

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    HALTED
  } core_state_t;

endpackage

// File: hw/pin_serializer.sv
// Pin serializer: nine-frame engine moving one word transaction over 8-bit pins
`timescale 1ns/1ps
`include "cpu_params.svh"

module pin_serializer
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  cpu_bus_if.ser    bus,
  output pin_byte_t pin_out,
  output pin_byte_t pin_io_out,
  output pin_byte_t pin_io_oe,
  input  pin_byte_t pin_io_in
);

  frame_t frame;
  logic   slot_act;     // Current nine frames carry a transaction
  logic   slot_we;
  addr_t  slot_addr;
  word_t  slot_wdata;
  logic [`CPU_WORD_W-`PIN_W-1:0] rd_shift;  // Read bytes 0 to 2

  logic   at_latch;
  logic   last_frame;
  logic   out_phase;
  logic   in_phase;
  logic   src_act;
  logic   src_we;
  addr_t  src_addr;
  word_t  src_wdata;
  logic [$clog2(`BYTES_PER_WORD)-1:0] lane;

  assign at_latch   = (frame == '0);
  assign last_frame = (frame == frame_t'(`FRAMES_PER_ACCESS - 1));
  // Frames 0 to 3 load the registered pins for frames 1 to 4
  assign out_phase  = (frame < frame_t'(`ADDR_FRAME0 + `BYTES_PER_WORD - 1));
  assign in_phase   = (frame >= frame_t'(`READ_FRAME0));
  assign lane       = frame[$clog2(`BYTES_PER_WORD)-1:0];

  // Byte 0 goes out at the latch edge, so take it from the bus directly
  assign src_act   = at_latch ? bus.req   : slot_act;
  assign src_we    = at_latch ? bus.we    : slot_we;
  assign src_addr  = at_latch ? bus.addr  : slot_addr;
  assign src_wdata = at_latch ? bus.wdata : slot_wdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '0;
    end else if (last_frame) begin
      frame <= '0;
    end else begin
      frame <= frame + frame_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_act <= 1'b0;
      slot_we  <= 1'b0;
    end else if (at_latch) begin
      slot_act <= bus.req;               // Low req leaves an idle slot
      slot_we  <= bus.we & bus.req;
    end
  end

  always_ff @(posedge clk) begin
    if (at_latch) begin
      slot_addr  <= bus.addr;
      slot_wdata <= bus.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pin_out    <= '0;
      pin_io_out <= '0;
      pin_io_oe  <= '0;
    end else if (out_phase && src_act) begin
      pin_out    <= src_addr[lane*`PIN_W +: `PIN_W];
      pin_io_out <= src_we ? src_wdata[lane*`PIN_W +: `PIN_W] : '0;
      pin_io_oe  <= {`PIN_W{src_we}};    // Drive uio only for writes
    end else begin
      pin_out    <= '0;
      pin_io_out <= '0;
      pin_io_oe  <= '0;
    end
  end

  // Read bytes arrive LSB first and shift down from the top
  always_ff @(posedge clk) begin
    if (in_phase && !last_frame) begin
      rd_shift <= {pin_io_in, rd_shift[`CPU_WORD_W-`PIN_W-1:`PIN_W]};
    end
    if (last_frame) begin
      bus.rdata <= {pin_io_in, rd_shift};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.done <= 1'b0;
    end else begin
      bus.done <= last_frame & slot_act;  // Lands in the next frame 0
    end
  end

  a_oe_window: assert property (@(posedge clk) disable iff (!rst_n)
    (pin_io_oe != '0) |->
      (frame >= frame_t'(`ADDR_FRAME0) &&
       frame <  frame_t'(`ADDR_FRAME0 + `BYTES_PER_WORD)))
    else $error("uio_oe driven outside the address frames");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    bus.done |=> !bus.done)
    else $error("done held for more than one cycle");

endmodule

// File: tests/cpu_pin_stim.txt
// Header: program words, data words, expected stores. Then the memory image from address 0,
// then expected stores as (address, data) pairs. Hex, one word per token.
00000013 00000008 00000004
10000013  // 00 LOAD  0x13
20000014  // 01 ADD   0x14, wraps
40000017  // 02 STORE 0x17
30000015  // 03 SUB   0x15, wraps below zero
40000018  // 04 STORE 0x18
6000000B  // 05 JZ    0x0B, not taken
50000008  // 06 JUMP  0x08
F0000000  // 07 HALT, skipped
10000015  // 08 LOAD  0x15
30000015  // 09 SUB   0x15, acc becomes zero
6000000D  // 0A JZ    0x0D, taken
F0000000  // 0B HALT, skipped
00000000  // 0C NOP, skipped
20000016  // 0D ADD   0x16
40000019  // 0E STORE 0x19
70000000  // 0F unused code acts as NOP
10000018  // 10 LOAD  0x18, reads back a stored word
4000001A  // 11 STORE 0x1A
F0000000  // 12 HALT
FFFFFFF0 00000025 00000100 12345678  // 13..16 data
00000000 00000000 00000000 00000000  // 17..1A store targets
00000017 00000015
00000018 FFFFFF15
00000019 12345678
0000001A FFFFFF15

// File: tests/tb_cpu_pin.sv
// Testbench with clock, reset, pin-level memory model, instruction set reference model and checks
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_pin;

  localparam int CLK_NS     = 100;
  localparam int RST_CYCLES = 16;
  localparam int FRAMES     = `FRAMES_PER_ACCESS;
  localparam int IDLE_SLOTS = 10;                     // Idle slots watched after HALT
  localparam int STIM_WORDS = 128;
  localparam int MEM_WORDS  = 64;
  localparam int IMAGE_BASE = 3;                      // First word after the stim header
  localparam int OPND_W     = `CPU_WORD_W - `OP_W;

  localparam logic [`OP_W-1:0] OP_LOAD  = 4'd1;
  localparam logic [`OP_W-1:0] OP_ADD   = 4'd2;
  localparam logic [`OP_W-1:0] OP_SUB   = 4'd3;
  localparam logic [`OP_W-1:0] OP_STORE = 4'd4;
  localparam logic [`OP_W-1:0] OP_JUMP  = 4'd5;
  localparam logic [`OP_W-1:0] OP_JZ    = 4'd6;
  localparam logic [`OP_W-1:0] OP_HALT  = 4'd15;

  typedef enum {PH_FETCH, PH_DATA, PH_HALTED} ref_phase_t;

  logic              clk;
  logic              rst_n;
  logic [`PIN_W-1:0] ui_in;
  logic [`PIN_W-1:0] uo_out;
  logic [`PIN_W-1:0] uio_in;
  logic [`PIN_W-1:0] uio_out;
  logic [`PIN_W-1:0] uio_oe;
  logic              ena;

  logic [`CPU_WORD_W-1:0] stim    [STIM_WORDS];
  logic [`CPU_WORD_W-1:0] ext_mem [MEM_WORDS];   // Memory seen by the DUT pins
  logic [`CPU_WORD_W-1:0] ref_mem [MEM_WORDS];   // Copy owned by the ISA model

  int     prog_words;
  int     data_words;
  int     store_count;
  int     pair_base;                             // Start of expected store pairs
  int     store_idx;
  int     idle_slots;
  int     frame;
  longint limit_ns;
  bit     run_done;

  ref_phase_t             ref_phase;
  logic [`CPU_WORD_W-1:0] ref_pc;
  logic [`CPU_WORD_W-1:0] ref_acc;
  logic [`CPU_WORD_W-1:0] ref_ir;
  logic                   exp_idle;
  logic                   exp_write;
  logic [`CPU_WORD_W-1:0] exp_addr;
  logic [`CPU_WORD_W-1:0] exp_wdata;
  logic [`CPU_WORD_W-1:0] pin_addr;              // Assembled from uo_out
  logic [`CPU_WORD_W-1:0] pin_wdata;             // Assembled from uio_out
  logic [`CPU_WORD_W-1:0] rd_word;               // Word returned on uio_in

  cpu_pin_top UUT (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Frame position counted from the first rising edge after reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= 0;
    end else if (frame == FRAMES - 1) begin
      frame <= 0;
    end else begin
      frame <= frame + 1;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0d ns: %s (got %h, expected %h)", $time, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic load_stimulus();
    int data_acc;
    logic [`OP_W-1:0] op;
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("tests/cpu_pin_stim.txt", stim);
    prog_words  = int'(stim[0]);
    data_words  = int'(stim[1]);
    store_count = int'(stim[2]);
    pair_base   = IMAGE_BASE + prog_words + data_words;
    check_value(32'(prog_words + data_words <= MEM_WORDS), 32'd1,
                "memory image fits the memory model");
    check_value(32'(pair_base + 2 * store_count <= STIM_WORDS), 32'd1,
                "store list fits the stimulus array");
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < prog_words + data_words) begin
        ext_mem[i] = stim[IMAGE_BASE + i];
      end else begin
        ext_mem[i] = 32'hA5A5_0000 | 32'(i);     // Unused words tagged with their address
      end
      ref_mem[i] = ext_mem[i];
    end
    data_acc = 0;
    for (int i = 0; i < prog_words; i++) begin
      op = stim[IMAGE_BASE + i][`CPU_WORD_W-1 -: `OP_W];
      if (op >= OP_LOAD && op <= OP_STORE) begin
        data_acc++;                              // One data access per memory opcode
      end
    end
    limit_ns = longint'(prog_words + data_acc + 20) * FRAMES * CLK_NS;
  endtask

  // Next access as the instruction set rules dictate
  task automatic predict_access();
    logic [`OP_W-1:0] op;
    op        = ref_ir[`CPU_WORD_W-1 -: `OP_W];
    exp_idle  = 1'b0;
    exp_write = 1'b0;
    exp_addr  = '0;
    exp_wdata = '0;
    if (ref_phase == PH_HALTED) begin
      exp_idle = 1'b1;
    end else if (ref_phase == PH_FETCH) begin
      exp_addr = ref_pc;
    end else begin
      exp_addr = {{`OP_W{1'b0}}, ref_ir[OPND_W-1:0]};
      if (op == OP_STORE) begin
        check_value(32'(store_idx < store_count), 32'd1, "store beyond the expected list");
        exp_write = 1'b1;
        exp_wdata = stim[pair_base + 2 * store_idx + 1];
        check_value(exp_addr, stim[pair_base + 2 * store_idx], "store address in the list");
        check_value(ref_acc, exp_wdata, "model accumulator against listed store data");
      end
    end
  endtask

  task automatic step_isa_model();
    logic [`OP_W-1:0]       op;
    logic [`CPU_WORD_W-1:0] opnd;
    logic [`CPU_WORD_W-1:0] insn;
    insn = (ref_phase == PH_FETCH) ? ref_mem[int'(ref_pc)] : ref_ir;
    op   = insn[`CPU_WORD_W-1 -: `OP_W];
    opnd = {{`OP_W{1'b0}}, insn[OPND_W-1:0]};
    if (ref_phase == PH_FETCH) begin
      ref_pc = ref_pc + 32'd1;
      case (op)
        OP_LOAD, OP_ADD, OP_SUB, OP_STORE: begin
          ref_ir    = insn;
          ref_phase = PH_DATA;
        end
        OP_JUMP: ref_pc = opnd;
        OP_JZ:   ref_pc = (ref_acc == '0) ? opnd : ref_pc;
        OP_HALT: ref_phase = PH_HALTED;
        default: ;                               // NOP and unused codes
      endcase
    end else begin
      case (op)
        OP_LOAD: ref_acc = ref_mem[int'(opnd)];
        OP_ADD:  ref_acc = ref_acc + ref_mem[int'(opnd)];
        OP_SUB:  ref_acc = ref_acc - ref_mem[int'(opnd)];
        default: begin
          ref_mem[int'(opnd)] = ref_acc;
          store_idx++;
        end
      endcase
      ref_phase = PH_FETCH;
    end
  endtask

  // Address phase complete at the end of frame 4
  task automatic commit_access();
    rd_word = '0;
    if (exp_idle) begin
      idle_slots++;
      run_done = (idle_slots >= IDLE_SLOTS);
    end else begin
      check_value(32'(pin_addr < MEM_WORDS), 32'd1, "access address inside the memory model");
      if (exp_write) begin
        ext_mem[int'(pin_addr)] = pin_wdata;
      end else begin
        rd_word = ext_mem[int'(pin_addr)];
      end
      step_isa_model();
    end
  endtask

  // Runs on each falling edge while the registered pins are stable
  task automatic watch_pins();
    int k;
    k = frame - 1;
    if (frame >= 1 && frame <= 4) begin
      if (frame == 1) begin
        predict_access();
      end
      pin_addr[k * `PIN_W +: `PIN_W]  = uo_out;
      pin_wdata[k * `PIN_W +: `PIN_W] = uio_out;
      check_value(32'(uo_out), 32'(exp_addr[k * `PIN_W +: `PIN_W]),
                  $sformatf("address byte %0d on uo_out", k));
      check_value(32'(uio_oe), exp_write ? 32'h0000_00ff : 32'h0,
                  $sformatf("uio_oe in frame %0d", frame));
      check_value(32'(uio_out), exp_write ? 32'(exp_wdata[k * `PIN_W +: `PIN_W]) : 32'h0,
                  $sformatf("write byte %0d on uio_out", k));
      if (frame == 4) begin
        commit_access();
      end
      uio_in = '0;
    end else begin
      check_value(32'(uo_out), 32'h0, $sformatf("uo_out in frame %0d", frame));
      check_value(32'(uio_oe), 32'h0, $sformatf("uio_oe in frame %0d", frame));
      check_value(32'(uio_out), 32'h0, $sformatf("uio_out in frame %0d", frame));
      if (frame >= 5) begin
        uio_in = rd_word[(frame - 5) * `PIN_W +: `PIN_W];  // Read bytes LSB first
      end else begin
        uio_in = '0;
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    ui_in      = '0;
    uio_in     = '0;
    ena        = 1'b1;
    store_idx  = 0;
    idle_slots = 0;
    run_done   = 1'b0;
    ref_phase  = PH_FETCH;
    ref_pc     = '0;
    ref_acc    = '0;
    ref_ir     = '0;
    rd_word    = '0;
    load_stimulus();
    repeat (RST_CYCLES) @(negedge clk);
    check_value(32'(uo_out), 32'h0, "uo_out in reset");
    check_value(32'(uio_out), 32'h0, "uio_out in reset");
    check_value(32'(uio_oe), 32'h0, "uio_oe in reset");
    rst_n = 1'b1;
    while (!run_done) begin
      @(negedge clk);
      watch_pins();
    end
    check_value(32'(store_idx), 32'(store_count), "stores seen before halt");
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value(ext_mem[i], ref_mem[i], $sformatf("memory word %0d after halt", i));
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog sized from the program and its data accesses
  initial begin
    #1;
    #(limit_ns);
    $display("Timeout after %0d ns: the processor never halted", limit_ns);
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

endmodule
